/* mmioSys.f */
+incdir+src
src/mmioPkg.sv
src/pulseTimers.sv
src/gpioRegs.sv
src/sevenSegScan.sv
src/mmioResponder.sv
src/mmioCore.sv
tests/mmioCore_tb.sv

/* runSim.sh */
#!/bin/sh
# build the mmioCore testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mmioCore_tb -f mmioSys.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
! grep -q "TB FAILED" sim.log

/* src/gpioRegs.sv */
`default_nettype none

`include "mmioParams.svh"

module gpioRegs
(
	input wire logic clock,
	input wire logic rstN_i,
	input wire mmioPkg::addrT addr_i,
	input wire mmioPkg::opmT opm_i,
	input wire mmioPkg::dataT wrData_i,
	input wire logic usTick_i,
	input wire mmioPkg::pinsT pinsIn_i,
	output mmioPkg::pinsT pinsOut_o,
	output mmioPkg::dataT rdData_o,
	output mmioPkg::okT ok_o
);

	mmioPkg::accStateT accState;
	mmioPkg::dataT usecCnt;
	mmioPkg::dataT rdMux;
	logic hit;

	// decode of the three registers
	assign hit = (opm_i != `MMIO_OPM_IDLE) &&
		((addr_i == `MMIO_GPIO_OUT) || (addr_i == `MMIO_GPIO_IN) ||
		(addr_i == `MMIO_GPIO_USEC));

	always_comb
	begin
		case (addr_i)
			`MMIO_GPIO_OUT: rdMux = {16'h0000, pinsOut_o};
			`MMIO_GPIO_IN: rdMux = {16'h0000, pinsIn_i};
			`MMIO_GPIO_USEC: rdMux = usecCnt;
			default: rdMux = '0;
		endcase
	end

	// free running microsecond counter
	always_ff @(posedge clock)
	begin
		if (!rstN_i)
			usecCnt <= '0;
		else if (usTick_i)
			usecCnt <= usecCnt + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			accState <= mmioPkg::accIdle;
			pinsOut_o <= '0;
		end
		else
		begin
			case (accState)
				mmioPkg::accIdle:
					if (hit)
					begin
						accState <= mmioPkg::accDone;
						// writes to IN and USEC just complete
						if (opm_i == `MMIO_OPM_WR && addr_i == `MMIO_GPIO_OUT)
							pinsOut_o <= wrData_i[15:0];
					end
				mmioPkg::accDone:
					if (opm_i == `MMIO_OPM_IDLE)
						accState <= mmioPkg::accIdle;
				default:
					accState <= mmioPkg::accIdle;
			endcase
		end
	end

	// read value captured at the hit edge
	always_ff @(posedge clock)
	begin
		if (accState == mmioPkg::accIdle && hit)
			rdData_o <= rdMux;
	end

	assign ok_o = (accState == mmioPkg::accDone) ? `MMIO_OK_OK : `MMIO_OK_READY;

	okFollowsOpm: assert property (@(posedge clock) disable iff (!rstN_i)
		(ok_o == `MMIO_OK_OK) |-> ($past(opm_i) != `MMIO_OPM_IDLE));

endmodule

`default_nettype wire

/* src/mmioCore.sv */
`default_nettype none

module mmioCore
(
	input wire logic clock,
	input wire logic rstN_i,
	input wire mmioPkg::addrT mmioAddr_i,
	input wire mmioPkg::opmT mmioOpm_i,
	input wire mmioPkg::dataT mmioWrData_i,
	output mmioPkg::dataT mmioRdData_o,
	output mmioPkg::okT mmioOk_o,
	input wire mmioPkg::pinsT gpioPinsIn_i,
	output mmioPkg::pinsT gpioPinsOut_o,
	output mmioPkg::segCharT segChar_o,
	output mmioPkg::segSegT segSeg_o
);

	logic usTick;
	logic msTick;
	mmioPkg::dataT gpioRdData;
	mmioPkg::okT gpioOk;
	mmioPkg::dataT segRdData;
	mmioPkg::okT segOk;

	pulseTimers i_timers
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.usTick_o(usTick),
		.msTick_o(msTick)
	);

	gpioRegs i_gpio
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.addr_i(mmioAddr_i),
		.opm_i(mmioOpm_i),
		.wrData_i(mmioWrData_i),
		.usTick_i(usTick),
		.pinsIn_i(gpioPinsIn_i),
		.pinsOut_o(gpioPinsOut_o),
		.rdData_o(gpioRdData),
		.ok_o(gpioOk)
	);

	// display scanner, steps one digit per millisecond
	sevenSegScan i_seg
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.addr_i(mmioAddr_i),
		.opm_i(mmioOpm_i),
		.wrData_i(mmioWrData_i),
		.msTick_i(msTick),
		.rdData_o(segRdData),
		.ok_o(segOk),
		.segChar_o(segChar_o),
		.segSeg_o(segSeg_o)
	);

	mmioResponder i_resp
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.opm_i(mmioOpm_i),
		.gpioRdData_i(gpioRdData),
		.gpioOk_i(gpioOk),
		.segRdData_i(segRdData),
		.segOk_i(segOk),
		.rdData_o(mmioRdData_o),
		.ok_o(mmioOk_o)
	);

endmodule

`default_nettype wire

/* src/mmioParams.svh */
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// bus operation codes, held by the master while an access is open
`define MMIO_OPM_IDLE 5'h00
`define MMIO_OPM_RD 5'h0B
`define MMIO_OPM_WR 5'h13

// bus status codes
`define MMIO_OK_READY 2'd0
`define MMIO_OK_OK 2'd1
// hold and fault are reserved, no slave here drives them
`define MMIO_OK_HOLD 2'd2
`define MMIO_OK_FAULT 2'd3

// register map
`define MMIO_GPIO_OUT 32'hF000_E000
`define MMIO_GPIO_IN 32'hF000_E004
`define MMIO_GPIO_USEC 32'hF000_E008
`define MMIO_SEG_VAL 32'hF000_E010

// clocks per microsecond strobe (short for simulation)
`define CLKP_US_DIV 4
// microsecond strobes per millisecond strobe
`define CLKP_MS_DIV 8

// cycles before an unanswered access is completed with zero
`define MMIO_MISS_LIMIT 15

`endif

/* src/mmioPkg.sv */
`default_nettype none

package mmioPkg;

	// byte address on the MMIO bus
	typedef logic [31:0] addrT;

	// read and write data
	typedef logic [31:0] dataT;

	// operation code, see MMIO_OPM_*
	typedef logic [4:0] opmT;

	// bus status, see MMIO_OK_*
	typedef logic [1:0] okT;

	// gpio pin vector
	typedef logic [15:0] pinsT;

	// digit select, active low, one bit per digit
	typedef logic [7:0] segCharT;

	// segment pattern, active low
	// bits 0..6 are segments a..g, bit 7 is the decimal point
	typedef logic [7:0] segSegT;

	// slave access state
	typedef enum logic
	{
		accIdle,
		accDone
	} accStateT;

endpackage

`default_nettype wire

/* src/mmioResponder.sv */
`default_nettype none

`include "mmioParams.svh"

module mmioResponder
(
	input wire logic clock,
	input wire logic rstN_i,
	input wire mmioPkg::opmT opm_i,
	input wire mmioPkg::dataT gpioRdData_i,
	input wire mmioPkg::okT gpioOk_i,
	input wire mmioPkg::dataT segRdData_i,
	input wire mmioPkg::okT segOk_i,
	output mmioPkg::dataT rdData_o,
	output mmioPkg::okT ok_o
);

	localparam int unsigned missLimit = `MMIO_MISS_LIMIT;
	localparam int unsigned missCntW = $clog2(missLimit + 1);

	logic [missCntW-1:0] missCnt;
	logic anyAnswer;
	logic missDone;

	assign anyAnswer = (gpioOk_i != `MMIO_OK_READY) || (segOk_i != `MMIO_OK_READY);
	assign missDone = (opm_i != `MMIO_OPM_IDLE) && (missCnt == missCntW'(missLimit));

	// fixed priority, gpio first
	always_comb
	begin
		rdData_o = '0;
		ok_o = `MMIO_OK_READY;
		if (gpioOk_i != `MMIO_OK_READY)
		begin
			rdData_o = gpioRdData_i;
			ok_o = gpioOk_i;
		end
		else if (segOk_i != `MMIO_OK_READY)
		begin
			rdData_o = segRdData_i;
			ok_o = segOk_i;
		end
		else if (missDone)
			ok_o = `MMIO_OK_OK;
	end

	// counts unanswered cycles, saturates at the limit
	always_ff @(posedge clock)
	begin
		if (!rstN_i || opm_i == `MMIO_OPM_IDLE)
			missCnt <= '0;
		else if (!anyAnswer && missCnt != missCntW'(missLimit))
			missCnt <= missCnt + 1'b1;
	end

	oneSlaveOnly: assert property (@(posedge clock) disable iff (!rstN_i)
		!((gpioOk_i != `MMIO_OK_READY) && (segOk_i != `MMIO_OK_READY)));

endmodule

`default_nettype wire

/* src/pulseTimers.sv */
`default_nettype none

`include "mmioParams.svh"

module pulseTimers
(
	input wire logic clock,
	input wire logic rstN_i,
	output logic usTick_o,
	output logic msTick_o
);

	localparam int unsigned usDiv = `CLKP_US_DIV;
	localparam int unsigned msDiv = `CLKP_MS_DIV;
	localparam int unsigned usCntW = (usDiv > 1) ? $clog2(usDiv) : 1;
	localparam int unsigned msCntW = (msDiv > 1) ? $clog2(msDiv) : 1;

	logic [usCntW-1:0] usCnt;
	logic [msCntW-1:0] msCnt;
	logic usWrap;
	logic msWrap;

	// last clock of the microsecond period
	assign usWrap = (usCnt == usCntW'(usDiv - 1));
	assign msWrap = (msCnt == msCntW'(msDiv - 1));

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			usCnt <= '0;
			msCnt <= '0;
			usTick_o <= 1'b0;
			msTick_o <= 1'b0;
		end
		else
		begin
			usCnt <= usWrap ? '0 : usCnt + 1'b1;
			usTick_o <= usWrap;
			// ms strobe lines up with the us strobe that closes it
			msTick_o <= usWrap && msWrap;
			if (usWrap)
				msCnt <= msWrap ? '0 : msCnt + 1'b1;
		end
	end

	msNeedsUs: assert property (@(posedge clock) disable iff (!rstN_i)
		msTick_o |-> usTick_o);

endmodule

`default_nettype wire

/* src/sevenSegScan.sv */
`default_nettype none

`include "mmioParams.svh"

module sevenSegScan
(
	input wire logic clock,
	input wire logic rstN_i,
	input wire mmioPkg::addrT addr_i,
	input wire mmioPkg::opmT opm_i,
	input wire mmioPkg::dataT wrData_i,
	input wire logic msTick_i,
	output mmioPkg::dataT rdData_o,
	output mmioPkg::okT ok_o,
	output mmioPkg::segCharT segChar_o,
	output mmioPkg::segSegT segSeg_o
);

	mmioPkg::accStateT accState;
	mmioPkg::dataT segVal;
	logic [2:0] digitIdx;
	logic [2:0] nextIdx;
	logic hit;

	// common anode gfedcba, decimal point off
	function automatic mmioPkg::segSegT hexSeg(input logic [3:0] nib);
		case (nib)
			4'h0: hexSeg = 8'hC0;
			4'h1: hexSeg = 8'hF9;
			4'h2: hexSeg = 8'hA4;
			4'h3: hexSeg = 8'hB0;
			4'h4: hexSeg = 8'h99;
			4'h5: hexSeg = 8'h92;
			4'h6: hexSeg = 8'h82;
			4'h7: hexSeg = 8'hF8;
			4'h8: hexSeg = 8'h80;
			4'h9: hexSeg = 8'h90;
			4'hA: hexSeg = 8'h88;
			4'hB: hexSeg = 8'h83;
			4'hC: hexSeg = 8'hC6;
			4'hD: hexSeg = 8'hA1;
			4'hE: hexSeg = 8'h86;
			default: hexSeg = 8'h8E;
		endcase
	endfunction

	assign hit = (opm_i != `MMIO_OPM_IDLE) && (addr_i == `MMIO_SEG_VAL);
	assign nextIdx = msTick_i ? digitIdx + 3'd1 : digitIdx;

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			accState <= mmioPkg::accIdle;
			segVal <= '0;
		end
		else if (accState == mmioPkg::accIdle)
		begin
			if (hit)
			begin
				accState <= mmioPkg::accDone;
				if (opm_i == `MMIO_OPM_WR)
					segVal <= wrData_i;
			end
		end
		else if (opm_i == `MMIO_OPM_IDLE)
			accState <= mmioPkg::accIdle;
	end

	always_ff @(posedge clock)
	begin
		if (accState == mmioPkg::accIdle && hit)
			rdData_o <= segVal;
	end

	assign ok_o = (accState == mmioPkg::accDone) ? `MMIO_OK_OK : `MMIO_OK_READY;

	// select and pattern both registered so they switch in the same cycle
	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			digitIdx <= '0;
			segChar_o <= 8'hFE;
			segSeg_o <= hexSeg(4'h0);
		end
		else
		begin
			digitIdx <= nextIdx;
			segChar_o <= mmioPkg::segCharT'(~(8'h01 << nextIdx));
			segSeg_o <= hexSeg(segVal[{nextIdx, 2'b00} +: 4]);
		end
	end

	oneDigitLow: assert property (@(posedge clock) disable iff (!rstN_i)
		$onehot(~segChar_o));

endmodule

`default_nettype wire

/* tests/mmioCore_tb.sv */
`default_nettype none

`include "mmioParams.svh"

module mmioCore_tb;

	localparam int clkHalf = 20;
	localparam int driveDelay = 5;
	localparam int ackTimeout = 100;
	localparam int scanTimeout = 4 * `CLKP_US_DIV * `CLKP_MS_DIV;
	localparam int usecGap = 8 * `CLKP_US_DIV;

	logic clock;
	logic rstN;
	mmioPkg::addrT mmioAddr;
	mmioPkg::opmT mmioOpm;
	mmioPkg::dataT mmioWrData;
	mmioPkg::dataT mmioRdData;
	mmioPkg::okT mmioOk;
	mmioPkg::pinsT pinsIn;
	mmioPkg::pinsT pinsOut;
	mmioPkg::segCharT segChar;
	mmioPkg::segSegT segSeg;

	int errorCount;
	int timeoutCount;
	bit timedOut;
	bit haveUsec;
	mmioPkg::dataT lastUsec;
	// last value written to the display register
	mmioPkg::dataT segShadow;
	int unsigned seedVal;

	mmioCore i_dut
	(
		.clock(clock),
		.rstN_i(rstN),
		.mmioAddr_i(mmioAddr),
		.mmioOpm_i(mmioOpm),
		.mmioWrData_i(mmioWrData),
		.mmioRdData_o(mmioRdData),
		.mmioOk_o(mmioOk),
		.gpioPinsIn_i(pinsIn),
		.gpioPinsOut_o(pinsOut),
		.segChar_o(segChar),
		.segSeg_o(segSeg)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#clkHalf clock = ~clock;
	end

	task automatic checkData(input string name, input mmioPkg::dataT got,
		input mmioPkg::dataT exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkPins(input string name, input mmioPkg::pinsT got,
		input mmioPkg::pinsT exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkSeg(input string name, input mmioPkg::segSegT got,
		input mmioPkg::segSegT exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkChar(input string name, input mmioPkg::segCharT got,
		input mmioPkg::segCharT exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkOk(input string name, input mmioPkg::okT got, input mmioPkg::okT exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic reportProblem(input string what);
		errorCount++;
		$display("Error: %s", what);
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		timedOut = 1'b1;
		$display("Timeout: %s", what);
	endtask

	task automatic checkLatency(input mmioPkg::addrT addr, input int cycles, input int exp);
		if (!timedOut && cycles != exp)
			reportProblem($sformatf("access to %h took %0d cycles instead of %0d",
				addr, cycles, exp));
	endtask

	// counter must have moved on since the previous read
	task automatic checkUsec(input mmioPkg::dataT got);
		if (haveUsec && !(got > lastUsec))
		begin
			errorCount++;
			$display("Fail mmioRdData_o: USEC read %h, expected above %h", got, lastUsec);
		end
		lastUsec = got;
		haveUsec = 1'b1;
	endtask

	// lit segments per hex digit in gfedcba order
	// inverted below for the common anode display
	function automatic mmioPkg::segSegT segPattern(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		segPattern = {1'b1, ~lit};
	endfunction

	// one bus access
	// cycles counts the clocks from driving opm to OK
	task automatic busAccess(input mmioPkg::opmT opm, input mmioPkg::addrT addr,
		input mmioPkg::dataT wrData, output mmioPkg::dataT rdData, output int cycles);
		bit seen;
		int gap;
		seen = 1'b0;
		cycles = 0;
		rdData = '0;
		@(posedge clock);
		#driveDelay;
		mmioAddr = addr;
		mmioWrData = wrData;
		mmioOpm = opm;
		while (!seen && cycles < ackTimeout)
		begin
			@(negedge clock);
			if (mmioOk == `MMIO_OK_OK)
				seen = 1'b1;
			else
				cycles++;
		end
		if (!seen)
			reportTimeout($sformatf("no OK status for the access to %h", addr));
		else
			rdData = mmioRdData;
		@(posedge clock);
		#driveDelay;
		mmioOpm = `MMIO_OPM_IDLE;
		@(posedge clock);
		@(negedge clock);
		checkOk("mmioOk_o", mmioOk, `MMIO_OK_READY);
		gap = $urandom % 4;
		repeat (gap) @(posedge clock);
	endtask

	// follow the digit scan and compare each digit with the register nibble
	task automatic scanDisplay(input int changes);
		mmioPkg::segCharT prevChar;
		int seen;
		int waitCnt;
		int digit;
		int lowBits;
		prevChar = segChar;
		seen = 0;
		while (!timedOut && seen < changes)
		begin
			waitCnt = 0;
			@(negedge clock);
			while (segChar == prevChar && waitCnt < scanTimeout)
			begin
				@(negedge clock);
				waitCnt++;
			end
			if (segChar == prevChar)
				reportTimeout("digit select did not advance");
			else
			begin
				prevChar = segChar;
				seen++;
				lowBits = 0;
				digit = 0;
				for (int k = 0; k < 8; k++)
				begin
					if (!segChar[k])
					begin
						lowBits++;
						digit = k;
					end
				end
				if (lowBits != 1)
				begin
					errorCount++;
					$display("Fail segChar_o: got %h, expected exactly one low bit", segChar);
				end
				else
					checkSeg("segSeg_o", segSeg, segPattern(segShadow[digit * 4 +: 4]));
			end
		end
	endtask

	initial
	begin
		int fd;
		int fields;
		int cycles;
		string line;
		logic [7:0] kind;
		mmioPkg::addrT addr;
		mmioPkg::dataT data;
		mmioPkg::dataT expVal;
		mmioPkg::dataT rdData;
		seedVal = $urandom(83);
		errorCount = 0;
		timeoutCount = 0;
		timedOut = 1'b0;
		haveUsec = 1'b0;
		lastUsec = '0;
		segShadow = '0;
		rstN = 1'b0;
		mmioAddr = '0;
		mmioOpm = `MMIO_OPM_IDLE;
		mmioWrData = '0;
		pinsIn = '0;
		repeat (10) @(posedge clock);
		#driveDelay;
		rstN = 1'b1;

		// state straight out of reset
		@(negedge clock);
		checkOk("mmioOk_o", mmioOk, `MMIO_OK_READY);
		checkData("mmioRdData_o", mmioRdData, '0);
		checkPins("gpioPinsOut_o", pinsOut, '0);
		checkChar("segChar_o", segChar, 8'hFE);
		checkSeg("segSeg_o", segSeg, segPattern(4'h0));

		fd = $fopen("tests/mmioCore_testdata.txt", "r");
		if (fd == 0)
			reportProblem("cannot open tests/mmioCore_testdata.txt");
		else
		begin
			while (!timedOut && $fgets(line, fd) != 0)
			begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%c %h %h %h", kind, addr, data, expVal);
				if (fields != 4)
				begin
					reportProblem($sformatf("unreadable test data line: %s", line));
					continue;
				end
				case (kind)
					"W":
					begin
						busAccess(`MMIO_OPM_WR, addr, data, rdData, cycles);
						checkLatency(addr, cycles, 1);
						checkPins("gpioPinsOut_o", pinsOut, expVal[15:0]);
						if (addr == `MMIO_SEG_VAL)
							segShadow = data;
					end
					"R":
					begin
						if (addr == `MMIO_GPIO_USEC)
							repeat (usecGap) @(posedge clock);
						busAccess(`MMIO_OPM_RD, addr, '0, rdData, cycles);
						checkLatency(addr, cycles, 1);
						if (addr == `MMIO_GPIO_USEC)
							checkUsec(rdData);
						else
							checkData("mmioRdData_o", rdData, expVal);
					end
					"I":
					begin
						@(posedge clock);
						#driveDelay;
						pinsIn = data[15:0];
					end
					"M":
					begin
						busAccess(`MMIO_OPM_RD, addr, '0, rdData, cycles);
						checkLatency(addr, cycles, `MMIO_MISS_LIMIT);
						checkData("mmioRdData_o", rdData, expVal);
					end
					default:
						reportProblem($sformatf("unknown operation kind in line: %s", line));
				endcase
			end
			$fclose(fd);
		end

		if (!timedOut)
			scanDisplay(16);

		$display("closing: %0d check errors, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/mmioCore_testdata.txt */
# columns: kind address data expected, all hex after the kind letter
# R read, W write, I set input pins, M read of an unmapped address
# W compares gpioPinsOut_o after the write with the expected column
# reads of the USEC address ignore expected and must count upwards
W F000E000 0000A5C3 0000A5C3
R F000E000 00000000 0000A5C3
W F000E000 12345678 00005678
R F000E000 00000000 00005678
W F000E000 FFFF0000 00000000
R F000E000 00000000 00000000
W F000E000 00003C96 00003C96
I 00000000 0000BEEF 00000000
R F000E004 00000000 0000BEEF
I 00000000 00000001 00000000
R F000E004 00000000 00000001
W F000E004 FFFFFFFF 00003C96
R F000E004 00000000 00000001
R F000E000 00000000 00003C96
R F000E008 00000000 00000000
R F000E008 00000000 00000000
W F000E008 00000000 00003C96
R F000E008 00000000 00000000
M F000E00C 00000000 00000000
M 00000000 00000000 00000000
M F000F000 00000000 00000000
W F000E010 89ABCDEF 00003C96
R F000E010 00000000 89ABCDEF
W F000E010 0F1E2D3C 00003C96
R F000E010 00000000 0F1E2D3C
R F000E000 00000000 00003C96
W F000E010 7A3C51E6 00003C96
R F000E010 00000000 7A3C51E6
